/* logic/zports_pkg.sv */
package zports_pkg;

	//////////////////////////////////////////////////
	// port addresses (low byte unless noted)
	localparam logic [7:0] port_fe     = 8'hfe;
	localparam logic [7:0] port_fd     = 8'hfd;
	localparam logic [7:0] port_f7     = 8'hf7;
	localparam logic [7:0] port_cv1    = 8'hfb; // covox
	localparam logic [7:0] port_cv2    = 8'hdd;
	localparam logic [7:0] port_sd0    = 8'h0f; // soundrive
	localparam logic [7:0] port_sd1    = 8'h1f;
	localparam logic [7:0] port_sd2    = 8'h4f;
	localparam logic [7:0] port_sd3    = 8'h5f;
	localparam logic [7:0] port_kjoy   = 8'h1f;
	localparam logic [7:0] port_kmouse = 8'hdf;

	// full 16-bit compare
	localparam logic [15:0] port_xt_addr = 16'h55ff;
	localparam logic [15:0] port_xt_data = 16'h56ff;

	// xt register numbers
	localparam logic [7:0] xreg_border  = 8'h00;
	localparam logic [7:0] xreg_vconfig = 8'h08;
	localparam logic [7:0] xreg_paladdr = 8'h09;

	//////////////////////////////////////////////////
	// select codes out of the decode stage
	localparam logic [3:0] sel_none    = 4'd0;
	localparam logic [3:0] sel_fe      = 4'd1;
	localparam logic [3:0] sel_7ffd    = 4'd2;
	localparam logic [3:0] sel_eff7    = 4'd3;
	localparam logic [3:0] sel_covox   = 4'd4;
	localparam logic [3:0] sel_sd0     = 4'd5;
	localparam logic [3:0] sel_sd1     = 4'd6;
	localparam logic [3:0] sel_sd2     = 4'd7;
	localparam logic [3:0] sel_sd3     = 4'd8;
	localparam logic [3:0] sel_xt_addr = 4'd9;
	localparam logic [3:0] sel_xt_data = 4'd10;

	// written byte as seen by port fe
	typedef struct packed {
		logic [2:0] spare;
		logic       beep;
		logic       tape_out;
		logic [2:0] border;
	} fe_bits_t;

	// same byte as seen by port 7ffd
	typedef struct packed {
		logic [1:0] page_hi;
		logic       lock48;   // also page bit 5 in 1M mode
		logic       rom;
		logic       screen;
		logic [2:0] page_lo;
	} p7ffd_bits_t;

	typedef union packed {
		fe_bits_t    fe;
		p7ffd_bits_t p7ffd;
	} io_byte_u;

endpackage

/* logic/io_strobe.sv */
module io_strobe
	import zports_pkg::*;
#(
	parameter int addr_w = 16
)(
	input  logic              zclk,
	input  logic              rst_n,
	input  logic [addr_w-1:0] a,
	input  logic [7:0]        din,
	input  logic              iorq_n,
	input  logic              wr_n,
	output logic              wr_stb,
	output logic [addr_w-1:0] cap_a,
	output logic [7:0]        cap_d
);

	logic wr_act;    // write cycle seen on the bus now
	logic wr_act_q;  // same, one edge earlier

	assign wr_act = ~(iorq_n | wr_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_act_q <= 1'b0;
			wr_stb   <= 1'b0;
		end
		else
		begin
			wr_act_q <= wr_act;
			wr_stb   <= wr_act & ~wr_act_q; // rising edge only
		end
	end

	// bus sample taken with the strobe
	always_ff @(posedge zclk)
	begin
		if (wr_act && !wr_act_q)
		begin
			cap_a <= a;
			cap_d <= din;
		end
	end

endmodule

/* logic/port_decode.sv */
module port_decode
	import zports_pkg::*;
#(
	parameter int addr_w = 16
)(
	input  logic              zclk,
	input  logic              rst_n,
	input  logic              wr_stb,
	input  logic [addr_w-1:0] cap_a,
	input  logic [7:0]        cap_d,
	input  logic              dos,
	output logic [3:0]        sel,
	output logic [7:0]        sel_d
);

	logic [7:0] loa;
	logic       shadow;
	logic [3:0] sel_n;

	assign loa    = cap_a[7:0];
	assign shadow = dos; // no BF shadow enable here

	//////////////////////////////////////////////////
	// address to select code
	always_comb
	begin
		sel_n = sel_none;
		if (cap_a[15:0] == port_xt_addr)
			sel_n = sel_xt_addr;
		else if (cap_a[15:0] == port_xt_data)
			sel_n = sel_xt_data;
		else
		begin
			case (loa)
				port_fe:
					sel_n = sel_fe;
				port_fd:
					if (!cap_a[15])
						sel_n = sel_7ffd;
				port_f7:
					if (!cap_a[12] && !shadow)
						sel_n = sel_eff7;
				port_cv1, port_cv2:
					sel_n = sel_covox;
				port_sd0:
					if (!shadow)
						sel_n = sel_sd0;
				port_sd1:
					if (!shadow)
						sel_n = sel_sd1;
				port_sd2:
					if (!shadow)
						sel_n = sel_sd2;
				port_sd3:
					if (!shadow)
						sel_n = sel_sd3;
				default:
					sel_n = sel_none;
			endcase
		end
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			sel <= sel_none;
		else
			sel <= wr_stb ? sel_n : sel_none; // one cycle only
	end

	always_ff @(posedge zclk)
	begin
		if (wr_stb)
			sel_d <= cap_d;
	end

endmodule

/* logic/paging_regs.sv */
module paging_regs
	import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic [3:0] sel,
	input  logic [7:0] sel_d,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	io_byte_u   p7ffd_q;
	logic [7:0] peff7_q;
	logic       block1m;   // eff7 bit 2
	logic       lock7ffd;

	assign block1m  = peff7_q[2];
	assign lock7ffd = p7ffd_q.p7ffd.lock48 & block1m;

	//////////////////////////////////////////////////
	// 7ffd and eff7
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
			peff7_q <= '0;
		end
		else
		begin
			if (sel == sel_7ffd && !lock7ffd)
				p7ffd_q <= sel_d;
			if (sel == sel_eff7)
				peff7_q <= sel_d;
		end
	end

	// 128K view while 1M mode is off
	assign p7ffd = block1m ?
		{3'b000, p7ffd_q.p7ffd.rom, p7ffd_q.p7ffd.screen, p7ffd_q.p7ffd.page_lo} :
		p7ffd_q;

	assign peff7 = block1m ?
		{peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} :
		peff7_q;

	// full 1 meg page number
	assign pent1m_page   = {p7ffd_q.p7ffd.page_hi, p7ffd_q.p7ffd.lock48,
	                        p7ffd_q.p7ffd.page_lo};
	assign pent1m_rom    = p7ffd_q.p7ffd.rom;
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_q[3];

endmodule

/* logic/sound_regs.sv */
module sound_regs
	import zports_pkg::*;
#(
	parameter int dac_count = 4 // 1, 2 or 4
)(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic [3:0] sel,
	input  logic [7:0] sel_d,
	output logic [7:0] psd0,
	output logic [7:0] psd1,
	output logic [7:0] psd2,
	output logic [7:0] psd3
);

	io_byte_u   d;
	logic [7:0] psd_q [dac_count];
	logic [1:0] sd_idx;

	assign d = sel_d;

	// beeper pattern per dac
	function automatic logic [7:0] fe_fill(input int idx, input logic beep, input logic tape);
		case (idx)
			0, 1:    return {8{beep}};
			2:       return {beep, {7{tape}}};
			default: return {8{tape}};
		endcase
	endfunction

	assign sd_idx = (sel == sel_sd1) ? 2'd1 :
	                (sel == sel_sd2) ? 2'd2 :
	                (sel == sel_sd3) ? 2'd3 : 2'd0;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			for (int i = 0; i < dac_count; i++)
				psd_q[i] <= '0;
		else
		begin
			case (sel)
				sel_fe:
					for (int i = 0; i < dac_count; i++)
						psd_q[i] <= fe_fill(i, d.fe.beep, d.fe.tape_out);
				sel_covox:
					for (int i = 0; i < dac_count; i++)
						psd_q[i] <= sel_d;
				sel_sd0, sel_sd1, sel_sd2, sel_sd3:
					for (int i = 0; i < dac_count; i++)
						if (i == int'(sd_idx) % dac_count)
							psd_q[i] <= sel_d; // soundrive, one byte
				default:
					;
			endcase
		end
	end

	// fewer dacs fold onto the outputs
	assign psd0 = psd_q[0 % dac_count];
	assign psd1 = psd_q[1 % dac_count];
	assign psd2 = psd_q[2 % dac_count];
	assign psd3 = psd_q[3 % dac_count];

endmodule

/* logic/xt_regs.sv */
module xt_regs
	import zports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  logic [3:0] sel,
	input  logic [7:0] sel_d,
	output logic [5:0] border,
	output logic [7:0] vcfg,
	output logic [7:0] sp_wa
);

	io_byte_u   d;
	logic [7:0] xt_addr;  // current xt register number

	assign d = sel_d;

	//////////////////////////////////////////////////
	// 55ff register address
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			xt_addr <= '0;
		else if (sel == sel_xt_addr)
			xt_addr <= sel_d;
	end

	//////////////////////////////////////////////////
	// 56ff data, plus the fe border
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			vcfg   <= '0;
			sp_wa  <= '0;
		end
		else if (sel == sel_fe)
		begin
			// spread grb over the 6-bit border
			border <= {d.fe.border[1], 1'b0, d.fe.border[2], 1'b0,
			           d.fe.border[0], 1'b0};
		end
		else if (sel == sel_xt_data)
		begin
			case (xt_addr)
				xreg_border:
					border <= sel_d[5:0];
				xreg_vconfig:
					vcfg <= sel_d;
				xreg_paladdr:
					sp_wa <= sel_d;
				default:
					; // unknown number, ignored
			endcase
		end
	end

endmodule

/* logic/port_read_mux.sv */
module port_read_mux
	import zports_pkg::*;
#(
	parameter int addr_w = 16
)(
	input  logic [addr_w-1:0] a,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              dos,
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  logic [4:0]        kj_in,
	input  logic [7:0]        mus_in,
	output logic [7:0]        dout,
	output logic              porthit,
	output logic              dataout
);

	logic [7:0] loa;

	assign loa = a[7:0];

	// any port handled here
	always_comb
	begin
		case (loa)
			port_fe, port_fd, port_cv1, port_cv2, port_kmouse:
				porthit = 1'b1;
			port_f7, port_sd0, port_sd1, port_sd2, port_sd3:
				porthit = !dos;
			default:
				porthit = (a[15:0] == port_xt_addr) || (a[15:0] == port_xt_data);
		endcase
	end

	always_comb
	begin
		case (loa)
			port_fe:     dout = {1'b1, tape_read, 1'b0, keys_in};
			port_kjoy:   dout = dos ? 8'hff : {3'b000, kj_in}; // kempston
			port_kmouse: dout = mus_in;
			default:     dout = 8'hff;
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

/* logic/zports_top.sv */
module zports_top
	import zports_pkg::*;
#(
	parameter int addr_w    = 16,
	parameter int dac_count = 4
)(
	input  logic              zclk,
	input  logic              rst_n,

	// z80 side
	input  logic [addr_w-1:0] a,
	input  logic [7:0]        din,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              dos,
	output logic [7:0]        dout,
	output logic              dataout,
	output logic              porthit,

	// board inputs
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  logic [4:0]        kj_in,
	input  logic [7:0]        mus_in,

	// register outputs
	output logic [5:0]        border,
	output logic [7:0]        psd0,
	output logic [7:0]        psd1,
	output logic [7:0]        psd2,
	output logic [7:0]        psd3,
	output logic [7:0]        vcfg,
	output logic [7:0]        sp_wa,
	output logic [7:0]        p7ffd,
	output logic [7:0]        peff7,
	output logic [5:0]        pent1m_page,
	output logic              pent1m_rom,
	output logic              pent1m_1m_on,
	output logic              pent1m_ram0_0
);

	logic              wr_stb;
	logic [addr_w-1:0] cap_a;
	logic [7:0]        cap_d;
	logic [3:0]        sel;
	logic [7:0]        sel_d;

	//////////////////////////////////////////////////
	// write pipeline
	io_strobe #(.addr_w(addr_w)) u_strobe (
		.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n), .wr_n(wr_n),
		.wr_stb(wr_stb), .cap_a(cap_a), .cap_d(cap_d));

	port_decode #(.addr_w(addr_w)) u_decode (
		.zclk(zclk), .rst_n(rst_n), .wr_stb(wr_stb), .cap_a(cap_a), .cap_d(cap_d),
		.dos(dos), .sel(sel), .sel_d(sel_d));

	paging_regs u_paging (
		.zclk(zclk), .rst_n(rst_n), .sel(sel), .sel_d(sel_d),
		.p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0));

	sound_regs #(.dac_count(dac_count)) u_sound (
		.zclk(zclk), .rst_n(rst_n), .sel(sel), .sel_d(sel_d),
		.psd0(psd0), .psd1(psd1), .psd2(psd2), .psd3(psd3));

	xt_regs u_xt (
		.zclk(zclk), .rst_n(rst_n), .sel(sel), .sel_d(sel_d),
		.border(border), .vcfg(vcfg), .sp_wa(sp_wa));

	// read side, combinational
	port_read_mux #(.addr_w(addr_w)) u_rdmux (
		.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .dos(dos), .keys_in(keys_in),
		.tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
		.dout(dout), .porthit(porthit), .dataout(dataout));

endmodule

/* testbench/tb_zports_tasks.svh */
task automatic abort_run();
	$display("Test failed");
	$fatal(1);
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] expv, input string what);
	if (got !== expv)
	begin
		$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expv);
		abort_run();
	end
endtask

task automatic check_six(input logic [5:0] got, input logic [5:0] expv, input string what);
	if (got !== expv)
	begin
		$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expv);
		abort_run();
	end
endtask

task automatic check_bit(input logic got, input logic expv, input string what);
	if (got !== expv)
	begin
		$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, expv);
		abort_run();
	end
endtask

// output codes as used in the test file
task automatic check_output(input logic [3:0] code, input logic [7:0] expv);
	case (code)
		4'h0: check_six(border, expv[5:0], "border");
		4'h1: check_byte(psd0, expv, "psd0");
		4'h2: check_byte(psd1, expv, "psd1");
		4'h3: check_byte(psd2, expv, "psd2");
		4'h4: check_byte(psd3, expv, "psd3");
		4'h5: check_byte(vcfg, expv, "vcfg");
		4'h6: check_byte(sp_wa, expv, "sp_wa");
		4'h7: check_byte(p7ffd, expv, "p7ffd");
		4'h8: check_byte(peff7, expv, "peff7");
		4'h9: check_six(pent1m_page, expv[5:0], "pent1m_page");
		4'ha: check_bit(pent1m_rom, expv[0], "pent1m_rom");
		4'hb: check_bit(pent1m_1m_on, expv[0], "pent1m_1m_on");
		4'hc: check_bit(pent1m_ram0_0, expv[0], "pent1m_ram0_0");
		default:
		begin
			$display("unknown output code %0d in the test file", code);
			abort_run();
		end
	endcase
endtask

//////////////////////////////////////////////////
// z80 bus cycles
task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input logic dos_v);
	int waited;
	@(posedge zclk);
	#5;
	a      = addr;
	din    = data;
	dos    = dos_v;
	iorq_n = 1'b0;
	wr_n   = 1'b0;
	waited = 0;
	while (dut.wr_stb !== 1'b1)
	begin
		@(negedge zclk);
		waited++;
		if (waited > 4)
		begin
			$display("timed out waiting for the write strobe at port %h", addr);
			abort_run();
		end
	end
	repeat (2)
	begin
		@(posedge zclk);
		#5;
	end
	iorq_n = 1'b1; // three cycles low in all
	wr_n   = 1'b1;
	repeat (2) @(posedge zclk);
	#5;
endtask

task automatic io_read(input logic [15:0] addr, input logic dos_v, input logic exp_out);
	@(posedge zclk);
	#5;
	a      = addr;
	dos    = dos_v;
	iorq_n = 1'b0;
	rd_n   = 1'b0;
	@(negedge zclk); // mux is combinational, settled by now
	check_byte(dout, read_model(addr, dos_v), "dout");
	check_bit(dataout, exp_out, "dataout");
	check_bit(porthit, exp_out, "porthit"); // read active, hit alone decides
	@(posedge zclk);
	#5;
	iorq_n = 1'b1;
	rd_n   = 1'b1;
	@(negedge zclk);
	check_bit(porthit, exp_out, "porthit"); // address still on the bus
	check_bit(dataout, 1'b0, "dataout");
	@(posedge zclk);
	#5;
endtask

/* testbench/tb_zports.sv */
module tb_zports;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_steps = 64;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [5:0]  border;
	logic [7:0]  psd0;
	logic [7:0]  psd1;
	logic [7:0]  psd2;
	logic [7:0]  psd3;
	logic [7:0]  vcfg;
	logic [7:0]  sp_wa;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;

	logic [15:0] steps [5*max_steps]; // five words per step
	logic [31:0] lcg_state;

	zports_top #(.addr_w(16), .dac_count(4)) dut (.*);

	always #50 zclk = ~zclk;

	`include "tb_zports_tasks.svh"

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected read data, by port
	function automatic logic [7:0] read_model(input logic [15:0] addr, input logic dos_v);
		case (addr[7:0])
			8'hfe:   return {1'b1, tape_read, 1'b0, keys_in};
			8'h1f:   return dos_v ? 8'hff : {3'b000, kj_in}; // kempston only outside dos
			8'hdf:   return mus_in;
			default: return 8'hff;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// one line of the test file
	task automatic run_step(input int s);
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [3:0]  code;
		logic [7:0]  expv;
		op   = steps[5*s][3:0];
		addr = steps[5*s+1];
		data = steps[5*s+2][7:0];
		code = steps[5*s+3][3:0];
		expv = steps[5*s+4][7:0];
		case (op)
			4'd1, 4'd2:
			begin
				io_write(addr, data, op == 4'd2);
				check_output(code, expv);
			end
			4'd3, 4'd4:
			begin
				lcg_state = lcg_next(lcg_state);
				keys_in   = lcg_state[12:8];
				kj_in     = lcg_state[20:16];
				mus_in    = lcg_state[31:24];
				tape_read = lcg_state[27];
				io_read(addr, op == 4'd4, expv[0]);
			end
			4'd5:
				check_output(code, expv);
			default:
			begin
				$display("unknown operation %0d in the test file", op);
				abort_run();
			end
		endcase
	endtask

	initial
	begin
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = '0;
		tape_read = 1'b0;
		kj_in     = '0;
		mus_in    = '0;
		lcg_state = 32'h8ebd_315e;
		for (int i = 0; i < 5*max_steps; i++)
			steps[i] = '0; // op 0 ends the list
		$readmemh("testbench/zports_tests.txt", steps);

		repeat (2) @(posedge zclk);
		#5 rst_n = 1'b1;
		@(negedge zclk);
		for (int k = 0; k < 9; k++)
			check_output(4'(k), 8'h00); // everything cleared by reset

		for (int s = 0; s < max_steps && steps[5*s] != 16'h0; s++)
			run_step(s);

		$display("Test passed");
		$finish;
	end

endmodule

/* testbench/zports_tests.txt */
// op addr data out expected; op 1/2 write dos low/high, 3/4 read dos low/high, 5 check
// out 0 border 1-4 psd0-3 5 vcfg 6 sp_wa 7 p7ffd 8 peff7 9 page a rom b 1m_on c ram0_0
1 00fe 15 0 0a
5 0000 00 1 ff
5 0000 00 2 ff
5 0000 00 3 80
5 0000 00 4 00
1 00fe 0a 0 20
5 0000 00 3 7f
5 0000 00 4 ff
1 00fb 5a 1 5a
5 0000 00 4 5a
1 001f 33 2 33
5 0000 00 1 5a
2 000f 77 1 5a
1 7ffd 35 7 35
5 0000 00 9 0d
5 0000 00 a 01
1 eff7 0c 8 00
5 0000 00 7 15
5 0000 00 b 00
5 0000 00 c 01
1 7ffd 02 9 0d
1 55ff 08 5 00
1 56ff a5 5 a5
1 55ff 09 6 00
1 56ff 3c 6 3c
1 55ff 00 0 20
1 56ff 2b 0 2b
1 55ff 07 5 a5
1 56ff 11 5 a5
5 0000 00 0 2b
3 00fe 00 0 01
3 001f 00 0 01
4 001f 00 0 00
3 00df 00 0 01
3 0055 00 0 00

/* vlog.f */
+incdir+testbench
logic/zports_pkg.sv
logic/io_strobe.sv
logic/port_decode.sv
logic/paging_regs.sv
logic/sound_regs.sv
logic/xt_regs.sv
logic/port_read_mux.sv
logic/zports_top.sv
testbench/tb_zports.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_zports -f vlog.f \
	--Mdir obj_dir -o sim_zports

./obj_dir/sim_zports
